// ==== bank_htu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bank_macros.svh"

module bank_htu (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          req_valid_i,
  output logic                         req_ready_o,
  input  wire bank_req_pkg::xbar_req_t req_i,
  output logic                         htu_sc_valid_o,
  input  wire                          htu_sc_ready_i,
  output bank_req_pkg::htu_sc_t        htu_sc_o
);

  import bank_req_pkg::*;
  import bank_mem_pkg::*;

  localparam int SETS  = `BANK_SETS;
  localparam int WAYS  = `BANK_WAYS;
  localparam int SET_W = $clog2(SETS);

  tag_t                       tag_q [SETS][WAYS];
  logic [SETS-1:0][WAYS-1:0]  valid_q;
  way_t [SETS-1:0]            lru_q;

  set_t            req_set;
  tag_t            req_tag;
  logic            req_write;
  logic            req_fire;
  logic [WAYS-1:0] hit_vec;
  logic            req_hit;
  logic            alloc_found;
  way_t            hit_way;
  way_t            alloc_way;
  way_t            sel_way;
  logic            init_done_q;
  logic            out_valid_q;
  htu_sc_t         out_q;

  assign req_set   = req_i.addr[SET_W-1:0];
  assign req_tag   = req_i.addr[$bits(line_addr_t)-1:SET_W];
  assign req_write = (req_i.opcode == OP_WRITE);

  // Tag compare and allocation choice.
  // An invalid way wins over the LRU way.
  always_comb begin
    hit_way     = '0;
    alloc_way   = lru_q[req_set];
    alloc_found = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      hit_vec[w] = valid_q[req_set][w] && (tag_q[req_set][w] == req_tag);
      if (hit_vec[w]) begin
        hit_way = way_t'(w);
      end
      if (!valid_q[req_set][w] && !alloc_found) begin
        alloc_way   = way_t'(w);
        alloc_found = 1'b1;
      end
    end
  end

  assign req_hit = |hit_vec;
  assign sel_way = req_hit ? hit_way : alloc_way;

  // Ready stays low for the first cycle out of reset.
  assign req_ready_o = init_done_q && (!out_valid_q || htu_sc_ready_i);
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      init_done_q <= 1'b0;
      out_valid_q <= 1'b0;
      valid_q     <= '0;
      lru_q       <= '0;
    end else begin
      init_done_q <= 1'b1;
      if (req_fire) begin
        out_valid_q <= 1'b1;
      end else if (htu_sc_ready_i) begin
        out_valid_q <= 1'b0;
      end
      // A read miss leaves the set untouched.
      if (req_fire && (req_hit || req_write)) begin
        lru_q[req_set] <= ~sel_way;
        if (req_write) begin
          valid_q[req_set][sel_way] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire && req_write) begin
      tag_q[req_set][sel_way] <= req_tag;
    end
    if (req_fire) begin
      out_q.ch_id   <= req_i.ch_id;
      out_q.opcode  <= req_i.opcode;
      out_q.hit     <= req_hit;
      out_q.set_way <= {req_set, sel_way};
      out_q.wbuf_id <= req_i.wbuf_id;
    end
  end

  assign htu_sc_valid_o = out_valid_q;
  assign htu_sc_o       = out_q;

  // Held result must not change until the controller takes it.
  a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    htu_sc_valid_o && !htu_sc_ready_i |=> htu_sc_valid_o && $stable(htu_sc_o));

endmodule

`default_nettype wire

// ==== bank_macros.svh ====
`ifndef BANK_MACROS_SVH
`define BANK_MACROS_SVH

// Geometry of one cache bank.
// The set index is taken from the low bits of the line address.
`define BANK_SETS 64

// Two ways per set, so one LRU bit per set is enough.
`define BANK_WAYS 2

// Line-sized entries in the write buffer.
// Loaded from outside and read by the SRAM controller on a linefill.
`define BANK_WBUF_ENTRIES 16

// Responses held between the SRAM controller and the crossbar.
`define BANK_RTN_DEPTH 2

`endif

// ==== bank_mem_pkg.sv ====
`default_nettype none

`include "bank_macros.svh"

package bank_mem_pkg;

  typedef logic [127:0] line_data_t;

  typedef logic [$clog2(`BANK_SETS)-1:0] set_t;
  typedef logic [$clog2(`BANK_WAYS)-1:0] way_t;

  // Data array index with the set in the upper bits.
  typedef struct packed {
    set_t set;
    way_t way;
  } set_way_t;

  typedef enum logic [2:0] {
    SC_IDLE,
    SC_READ,
    SC_WBUF_REQ,
    SC_WBUF_WAIT,
    SC_RESP
  } sc_state_e;

  typedef struct packed {
    bank_req_pkg::ch_id_t   ch_id;
    bank_req_pkg::bank_op_e opcode;
    logic                   hit;
    line_data_t             data;
  } bank_rsp_t;

endpackage

`default_nettype wire

// ==== bank_req_pkg.sv ====
`default_nettype none

`include "bank_macros.svh"

package bank_req_pkg;

  // Requester channel on the crossbar.
  typedef logic [1:0] ch_id_t;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1
  } bank_op_e;

  // Bits 31 to 4 of the byte address.
  typedef logic [27:0] line_addr_t;

  // Line address without the set index bits.
  typedef logic [$bits(line_addr_t)-$clog2(`BANK_SETS)-1:0] tag_t;

  typedef logic [$clog2(`BANK_WBUF_ENTRIES)-1:0] wbuf_id_t;

  typedef struct packed {
    ch_id_t     ch_id;
    bank_op_e   opcode;
    line_addr_t addr;
    wbuf_id_t   wbuf_id;
  } xbar_req_t;

  // Hit test result with the set/way index laid out as {set, way}.
  typedef struct packed {
    ch_id_t                                              ch_id;
    bank_op_e                                            opcode;
    logic                                                hit;
    logic [$clog2(`BANK_SETS)+$clog2(`BANK_WAYS)-1:0] set_way;
    wbuf_id_t                                            wbuf_id;
  } htu_sc_t;

endpackage

`default_nettype wire

// ==== bank_rtn.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bank_macros.svh"

module bank_rtn (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          sc_rtn_valid_i,
  output logic                         sc_rtn_ready_o,
  input  wire bank_mem_pkg::bank_rsp_t sc_rtn_i,
  output logic                         rsp_valid_o,
  input  wire                          rsp_ready_i,
  output bank_mem_pkg::bank_rsp_t      rsp_o
);

  import bank_mem_pkg::*;

  localparam int DEPTH = `BANK_RTN_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  bank_rsp_t        slot_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Full queue stalls the controller, the crossbar ready is not passed back.
  assign sc_rtn_ready_o = (count_q != CNT_W'(DEPTH));
  assign rsp_valid_o    = (count_q != '0);
  assign rsp_o          = slot_q[rd_ptr_q];
  assign push           = sc_rtn_valid_i && sc_rtn_ready_o;
  assign pop            = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q[wr_ptr_q] <= sc_rtn_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    count_q <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

// ==== bank_sram_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bank_macros.svh"

module bank_sram_controller (
  input  wire                           clk_i,
  input  wire                           rst_i,
  input  wire                           htu_sc_valid_i,
  output logic                          htu_sc_ready_o,
  input  wire bank_req_pkg::htu_sc_t    htu_sc_i,
  output logic                          wbuf_req_valid_o,
  input  wire                           wbuf_req_ready_i,
  output bank_req_pkg::wbuf_id_t        wbuf_req_id_o,
  input  wire                           wbuf_rtn_valid_i,
  output logic                          wbuf_rtn_ready_o,
  input  wire bank_mem_pkg::line_data_t wbuf_rtn_data_i,
  output logic                          sc_rtn_valid_o,
  input  wire                           sc_rtn_ready_i,
  output bank_mem_pkg::bank_rsp_t       sc_rtn_o
);

  import bank_req_pkg::*;
  import bank_mem_pkg::*;

  localparam int LINES = `BANK_SETS * `BANK_WAYS;

  line_data_t data_q [LINES];
  sc_state_e  state_q;
  sc_state_e  state_d;
  htu_sc_t    item_q;
  set_way_t   item_sw;
  line_data_t rsp_data_q;
  logic       htu_fire;
  logic       wbuf_rtn_fire;
  logic       sc_rtn_fire;

  assign item_sw = set_way_t'(item_q.set_way);

  assign htu_sc_ready_o   = (state_q == SC_IDLE);
  assign wbuf_req_valid_o = (state_q == SC_WBUF_REQ);
  assign wbuf_rtn_ready_o = (state_q == SC_WBUF_WAIT);
  assign sc_rtn_valid_o   = (state_q == SC_RESP);
  assign wbuf_req_id_o    = item_q.wbuf_id;

  assign htu_fire      = htu_sc_valid_i && htu_sc_ready_o;
  assign wbuf_rtn_fire = wbuf_rtn_valid_i && wbuf_rtn_ready_o;
  assign sc_rtn_fire   = sc_rtn_valid_o && sc_rtn_ready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SC_IDLE: begin
        if (htu_fire) begin
          if (htu_sc_i.opcode == OP_WRITE) begin
            state_d = SC_WBUF_REQ;
          end else if (htu_sc_i.hit) begin
            state_d = SC_READ;
          end else begin
            state_d = SC_RESP;
          end
        end
      end
      SC_READ:      state_d = SC_RESP;
      SC_WBUF_REQ:  if (wbuf_req_ready_i) state_d = SC_WBUF_WAIT;
      SC_WBUF_WAIT: if (wbuf_rtn_fire) state_d = SC_RESP;
      SC_RESP:      if (sc_rtn_fire) state_d = SC_IDLE;
      default:      state_d = SC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= SC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Response data starts at zero, which is what a read miss returns.
  always_ff @(posedge clk_i) begin
    if (htu_fire) begin
      item_q     <= htu_sc_i;
      rsp_data_q <= '0;
    end
    if (state_q == SC_READ) begin
      rsp_data_q <= data_q[item_sw];
    end
    // On a linefill the written line is also the response data.
    if (wbuf_rtn_fire) begin
      data_q[item_sw] <= wbuf_rtn_data_i;
      rsp_data_q      <= wbuf_rtn_data_i;
    end
  end

  always_comb begin
    sc_rtn_o.ch_id  = item_q.ch_id;
    sc_rtn_o.opcode = item_q.opcode;
    sc_rtn_o.hit    = item_q.hit;
    sc_rtn_o.data   = rsp_data_q;
  end

  // An accepted item is finished before the next one is taken.
  a_in_order: assert property (@(posedge clk_i) disable iff (rst_i)
    htu_fire |=> (!htu_sc_ready_o until_with sc_rtn_fire));

endmodule

`default_nettype wire

// ==== bank_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module bank_top (
  input  wire                           clk_i,
  input  wire                           rst_i,
  input  wire                           req_valid_i,
  output logic                          req_ready_o,
  input  wire bank_req_pkg::xbar_req_t  req_i,
  output logic                          rsp_valid_o,
  input  wire                           rsp_ready_i,
  output bank_mem_pkg::bank_rsp_t       rsp_o,
  input  wire                           wbuf_load_i,
  input  wire bank_req_pkg::wbuf_id_t   wbuf_load_id_i,
  input  wire bank_mem_pkg::line_data_t wbuf_load_data_i
);

  import bank_req_pkg::*;
  import bank_mem_pkg::*;

  logic       htu_sc_valid;
  logic       htu_sc_ready;
  htu_sc_t    htu_sc;
  logic       wbuf_req_valid;
  logic       wbuf_req_ready;
  wbuf_id_t   wbuf_req_id;
  logic       wbuf_rtn_valid;
  logic       wbuf_rtn_ready;
  line_data_t wbuf_rtn_data;
  logic       sc_rtn_valid;
  logic       sc_rtn_ready;
  bank_rsp_t  sc_rtn;

  bank_htu u_bank_htu (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_i          (req_i),
    .htu_sc_valid_o (htu_sc_valid),
    .htu_sc_ready_i (htu_sc_ready),
    .htu_sc_o       (htu_sc)
  );

  bank_sram_controller u_bank_sram_controller (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .htu_sc_valid_i   (htu_sc_valid),
    .htu_sc_ready_o   (htu_sc_ready),
    .htu_sc_i         (htu_sc),
    .wbuf_req_valid_o (wbuf_req_valid),
    .wbuf_req_ready_i (wbuf_req_ready),
    .wbuf_req_id_o    (wbuf_req_id),
    .wbuf_rtn_valid_i (wbuf_rtn_valid),
    .wbuf_rtn_ready_o (wbuf_rtn_ready),
    .wbuf_rtn_data_i  (wbuf_rtn_data),
    .sc_rtn_valid_o   (sc_rtn_valid),
    .sc_rtn_ready_i   (sc_rtn_ready),
    .sc_rtn_o         (sc_rtn)
  );

  bank_wbuffer u_bank_wbuffer (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .wbuf_load_i      (wbuf_load_i),
    .wbuf_load_id_i   (wbuf_load_id_i),
    .wbuf_load_data_i (wbuf_load_data_i),
    .wbuf_req_valid_i (wbuf_req_valid),
    .wbuf_req_ready_o (wbuf_req_ready),
    .wbuf_req_id_i    (wbuf_req_id),
    .wbuf_rtn_valid_o (wbuf_rtn_valid),
    .wbuf_rtn_ready_i (wbuf_rtn_ready),
    .wbuf_rtn_data_o  (wbuf_rtn_data)
  );

  bank_rtn u_bank_rtn (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .sc_rtn_valid_i (sc_rtn_valid),
    .sc_rtn_ready_o (sc_rtn_ready),
    .sc_rtn_i       (sc_rtn),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_o          (rsp_o)
  );

endmodule

`default_nettype wire

// ==== bank_wbuffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bank_macros.svh"

module bank_wbuffer (
  input  wire                           clk_i,
  input  wire                           rst_i,
  input  wire                           wbuf_load_i,
  input  wire bank_req_pkg::wbuf_id_t   wbuf_load_id_i,
  input  wire bank_mem_pkg::line_data_t wbuf_load_data_i,
  input  wire                           wbuf_req_valid_i,
  output logic                          wbuf_req_ready_o,
  input  wire bank_req_pkg::wbuf_id_t   wbuf_req_id_i,
  output logic                          wbuf_rtn_valid_o,
  input  wire                           wbuf_rtn_ready_i,
  output bank_mem_pkg::line_data_t      wbuf_rtn_data_o
);

  import bank_mem_pkg::*;

  line_data_t entry_q [`BANK_WBUF_ENTRIES];
  logic       rtn_valid_q;
  logic       req_fire;
  logic       rtn_fire;

  // One return at a time.
  assign wbuf_req_ready_o = !rtn_valid_q;
  assign req_fire         = wbuf_req_valid_i && wbuf_req_ready_o;
  assign rtn_fire         = rtn_valid_q && wbuf_rtn_ready_i;
  assign wbuf_rtn_valid_o = rtn_valid_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rtn_valid_q <= 1'b0;
    end else if (req_fire) begin
      rtn_valid_q <= 1'b1;
    end else if (rtn_fire) begin
      rtn_valid_q <= 1'b0;
    end
  end

  // External load port without a handshake.
  always_ff @(posedge clk_i) begin
    if (wbuf_load_i) begin
      entry_q[wbuf_load_id_i] <= wbuf_load_data_i;
    end
    if (req_fire) begin
      wbuf_rtn_data_o <= entry_q[wbuf_req_id_i];
    end
  end

  // The controller asks for a new line only after the previous one was taken.
  a_one_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    wbuf_req_valid_i |-> !rtn_valid_q);

endmodule

`default_nettype wire

// ==== tb_bank_model.svh ====
`ifndef TB_BANK_MODEL_SVH
`define TB_BANK_MODEL_SVH

// Reference state of the bank, updated when a request is accepted.
tag_t       m_tag   [`BANK_SETS][`BANK_WAYS];
logic       m_valid [`BANK_SETS][`BANK_WAYS];
int         m_lru   [`BANK_SETS];
line_data_t m_line  [`BANK_SETS][`BANK_WAYS];
line_data_t m_wbuf  [`BANK_WBUF_ENTRIES];

// Expected responses in request order.
bank_rsp_t  exp_q [$];
int         check_count;
int         error_count;

task automatic clear_model();
  for (int s = 0; s < `BANK_SETS; s++) begin
    m_lru[s] = 0;
    for (int w = 0; w < `BANK_WAYS; w++) begin
      m_valid[s][w] = 1'b0;
    end
  end
endtask

// Set is the line address modulo the set count, the tag is the quotient.
task automatic predict_rsp(input xbar_req_t req);
  int        set_idx;
  int        way;
  tag_t      tag;
  bank_rsp_t rsp;
  set_idx    = int'(req.addr % `BANK_SETS);
  tag        = tag_t'(req.addr / `BANK_SETS);
  rsp.ch_id  = req.ch_id;
  rsp.opcode = req.opcode;
  rsp.hit    = 1'b0;
  rsp.data   = '0;
  way        = m_lru[set_idx];
  for (int w = 0; w < `BANK_WAYS; w++) begin
    if (m_valid[set_idx][w] && m_tag[set_idx][w] == tag) begin
      rsp.hit = 1'b1;
      way     = w;
    end
  end
  // On a miss the lowest invalid way is taken before the LRU way.
  if (!rsp.hit) begin
    for (int w = `BANK_WAYS - 1; w >= 0; w--) begin
      if (!m_valid[set_idx][w]) way = w;
    end
  end
  if (req.opcode == OP_WRITE) begin
    m_tag[set_idx][way]   = tag;
    m_valid[set_idx][way] = 1'b1;
    m_line[set_idx][way]  = m_wbuf[req.wbuf_id];
    rsp.data              = m_line[set_idx][way];
  end else if (rsp.hit) begin
    rsp.data = m_line[set_idx][way];
  end
  if (rsp.hit || req.opcode == OP_WRITE) begin
    m_lru[set_idx] = (way == 0) ? 1 : 0;
  end
  exp_q.push_back(rsp);
endtask

task automatic check_line(input line_data_t got, input line_data_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAILED at %0t ns: line data %h, expected %h", $time, got, exp);
  end
endtask

task automatic check_rsp(input bank_rsp_t got, input bank_rsp_t exp);
  check_count++;
  if (got.ch_id !== exp.ch_id || got.opcode !== exp.opcode || got.hit !== exp.hit) begin
    error_count++;
    $display("FAILED at %0t ns: response ch %0d op %0d hit %0b, expected ch %0d op %0d hit %0b",
             $time, got.ch_id, got.opcode, got.hit, exp.ch_id, exp.opcode, exp.hit);
  end
  check_line(got.data, exp.data);
endtask

`endif

// ==== tb_bank_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bank_macros.svh"

module tb_bank_top;

  import bank_req_pkg::*;
  import bank_mem_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 8;
  localparam int TIMEOUT       = 200;
  localparam int RANDOM_CYCLES = 3000;

  logic       clk_i;
  logic       rst_i;
  logic       req_valid_i;
  logic       req_ready_o;
  xbar_req_t  req_i;
  logic       rsp_valid_o;
  logic       rsp_ready_i;
  bank_rsp_t  rsp_o;
  logic       wbuf_load_i;
  wbuf_id_t   wbuf_load_id_i;
  line_data_t wbuf_load_data_i;

  integer     seed;
  int         timeout_count;
  int         writes_pending;
  logic       accepted_q;
  logic       aborted;
  bank_rsp_t  exp_rsp;

  `include "tb_bank_model.svh"

  bank_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Model update and response check on each rising edge.
  always @(posedge clk_i) begin
    if (rst_i) begin
      clear_model();
      writes_pending = 0;
      accepted_q     = 1'b0;
    end else begin
      if (wbuf_load_i) m_wbuf[wbuf_load_id_i] = wbuf_load_data_i;
      accepted_q = req_valid_i && req_ready_o;
      if (accepted_q) begin
        predict_rsp(req_i);
        if (req_i.opcode == OP_WRITE) writes_pending++;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Response at %0t ns arrived with no request outstanding", $time);
        end else begin
          exp_rsp = exp_q.pop_front();
          check_rsp(rsp_o, exp_rsp);
          if (exp_rsp.opcode == OP_WRITE) writes_pending--;
        end
      end
    end
  end

  function automatic line_addr_t make_addr(input int tag, input int set_idx);
    make_addr = line_addr_t'(tag * `BANK_SETS + set_idx);
  endfunction

  function automatic line_data_t random_line();
    random_line = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic flag_timeout(input string what);
    timeout_count++;
    aborted = 1'b1;
    $display("Timeout at %0t ns: %s", $time, what);
  endtask

  task automatic pulse_reset();
    @(negedge clk_i);
    rst_i = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b0;
  endtask

  task automatic issue_req(input ch_id_t ch, input bank_op_e op, input line_addr_t addr,
                           input wbuf_id_t id);
    logic taken;
    if (aborted) return;
    @(negedge clk_i);
    req_valid_i   = 1'b1;
    req_i.ch_id   = ch;
    req_i.opcode  = op;
    req_i.addr    = addr;
    req_i.wbuf_id = id;
    taken         = 1'b0;
    for (int waited = 0; waited < TIMEOUT && !taken; waited++) begin
      @(posedge clk_i);
      taken = req_ready_o;
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    if (!taken) flag_timeout("request was not accepted");
  endtask

  task automatic drain_rsps();
    int waited;
    if (aborted) return;
    @(negedge clk_i);
    rsp_ready_i = 1'b1;
    waited      = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) flag_timeout("expected responses never arrived");
  endtask

  // Random traffic over sets 0 to 3 with three tags, so ways get evicted.
  task automatic run_random();
    int stall;
    int pick;
    stall = 0;
    for (int cyc = 0; cyc < RANDOM_CYCLES && !aborted; cyc++) begin
      @(negedge clk_i);
      rsp_ready_i = ($random(seed) & 3) != 0;
      wbuf_load_i = 1'b0;
      if (req_valid_i && !accepted_q) begin
        stall++;
        if (stall > TIMEOUT) flag_timeout("request stalled in random traffic");
      end else begin
        stall       = 0;
        req_valid_i = 1'b0;
        pick        = $random(seed) & 7;
        // Loads only while no write is in flight.
        if (pick == 0 && writes_pending == 0) begin
          wbuf_load_i      = 1'b1;
          wbuf_load_id_i   = wbuf_id_t'($random(seed));
          wbuf_load_data_i = random_line();
        end else if (pick > 2) begin
          pick          = 'h10 + $unsigned($random(seed)) % 3;
          req_valid_i   = 1'b1;
          req_i.ch_id   = ch_id_t'($random(seed));
          req_i.opcode  = ($random(seed) & 1) ? OP_WRITE : OP_READ;
          req_i.addr    = make_addr(pick, $random(seed) & 3);
          req_i.wbuf_id = wbuf_id_t'($random(seed));
        end
      end
    end
    // A request still offered keeps valid until it is taken.
    stall = 0;
    while (req_valid_i && !aborted) begin
      @(negedge clk_i);
      wbuf_load_i = 1'b0;
      stall++;
      if (accepted_q) begin
        req_valid_i = 1'b0;
      end else if (stall > TIMEOUT) begin
        flag_timeout("last random request was not accepted");
      end
    end
    wbuf_load_i = 1'b0;
  endtask

  initial begin
    seed             = 32'h7800;
    rst_i            = 1'b1;
    req_valid_i      = 1'b0;
    req_i            = '0;
    rsp_ready_i      = 1'b0;
    wbuf_load_i      = 1'b0;
    wbuf_load_id_i   = '0;
    wbuf_load_data_i = '0;
    check_count      = 0;
    error_count      = 0;
    timeout_count    = 0;
    aborted          = 1'b0;
    writes_pending   = 0;
    accepted_q       = 1'b0;
    pulse_reset();
    for (int i = 0; i < `BANK_WBUF_ENTRIES; i++) begin
      @(negedge clk_i);
      wbuf_load_i      = 1'b1;
      wbuf_load_id_i   = wbuf_id_t'(i);
      wbuf_load_data_i = random_line();
    end
    @(negedge clk_i);
    wbuf_load_i = 1'b0;
    rsp_ready_i = 1'b1;
    // Set 5 with tags 'h100, 'h200 and 'h300.
    issue_req(2'd1, OP_READ, make_addr('h100, 5), 4'd0);
    issue_req(2'd2, OP_WRITE, make_addr('h100, 5), 4'd1);
    issue_req(2'd3, OP_READ, make_addr('h100, 5), 4'd0);
    issue_req(2'd0, OP_WRITE, make_addr('h200, 5), 4'd2);
    // Third tag evicts the LRU way, the first line then misses.
    issue_req(2'd1, OP_WRITE, make_addr('h300, 5), 4'd3);
    issue_req(2'd2, OP_READ, make_addr('h100, 5), 4'd0);
    // Hit on 'h200 leaves 'h300 as the next victim.
    issue_req(2'd3, OP_READ, make_addr('h200, 5), 4'd0);
    issue_req(2'd0, OP_WRITE, make_addr('h100, 5), 4'd4);
    issue_req(2'd1, OP_READ, make_addr('h200, 5), 4'd0);
    issue_req(2'd2, OP_READ, make_addr('h300, 5), 4'd0);
    drain_rsps();
    run_random();
    drain_rsps();
    // Reset clears the valid bits, so a written line misses.
    pulse_reset();
    issue_req(2'd3, OP_READ, make_addr('h200, 5), 4'd0);
    drain_rsps();
    $display("Checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
bank_req_pkg.sv
bank_mem_pkg.sv
bank_htu.sv
bank_wbuffer.sv
bank_sram_controller.sv
bank_rtn.sv
bank_top.sv
tb_bank_top.sv
